//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    // instruction word with msb first
    typedef struct packed {
        logic [6:0]           funct7;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } inst_t;

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_op     = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    // alu funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load size funct3 where bit 2 means zero extend
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // selects sub and sra
    localparam int alt_bit_pos = 30;

    typedef struct packed {
        logic [xlen-1:0] i;
        logic [xlen-1:0] s;
        logic [xlen-1:0] b;
        logic [xlen-1:0] u;
        logic [xlen-1:0] j;
    } imm_set_t;

endpackage

`default_nettype wire

//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        cls_none,
        cls_ls,
        cls_alu,
        cls_jmp,
        cls_ldpc
    } uop_class_e;

    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge
    } br_cond_e;

    // valid means the decoder supplies val itself
    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] idx;
        logic [xlen-1:0]      val;
    } operand_t;

    typedef struct packed {
        logic       is_load;
        logic [1:0] size;
        logic       unsigned_ext;
    } mem_ctrl_t;

    typedef struct packed {
        logic     is_jal;
        logic     is_jalr;
        br_cond_e cond;
        logic     cmp_unsigned;
    } jmp_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      next_pc;
        uop_class_e           cls;
        operand_t             src1;
        operand_t             src2;
        operand_t             src3;
        logic [reg_idx_w-1:0] rd_idx;
        alu_op_e              alu_op;
        mem_ctrl_t            mem;
        jmp_ctrl_t            jmp;
        logic                 need_pc;
    } uop_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_fetch,
        st_holding
    } stage_state_e;

endpackage

`default_nettype wire

//--- fetch_handshake.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_handshake
    import decode_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic fetch_valid,
    input  logic down_ready,
    output logic in_ready,
    output logic out_valid,
    output logic load
);

    stage_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else if (start) begin
            // drops whatever is held
            state <= st_wait_fetch;
        end else begin
            case (state)
                st_wait_fetch: begin
                    if (fetch_valid) begin
                        state <= st_holding;
                    end
                end
                st_holding: begin
                    // old uop leaves, a new one may arrive on the same edge
                    if (down_ready) begin
                        if (fetch_valid) begin
                            state <= st_holding;
                        end else begin
                            state <= st_wait_fetch;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign in_ready = (state == st_wait_fetch) ||
                      ((state == st_holding) && down_ready);

    assign out_valid = (state == st_holding);

    assign load = in_ready && fetch_valid;

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import rv_isa_pkg::*;
(
    input  inst_t    word,
    output imm_set_t imm
);

    logic sign;

    assign sign = word.funct7[6];

    // I takes inst[31:20]
    assign imm.i = {
        {(xlen - 12){sign}},
        word.funct7,
        word.rs2
    };

    // S takes inst[31:25] and inst[11:7]
    assign imm.s = {
        {(xlen - 12){sign}},
        word.funct7,
        word.rd
    };

    // B holds bits 12, 11, 10:5 and 4:1
    assign imm.b = {
        {(xlen - 12){sign}},
        word.rd[0],
        word.funct7[5:0],
        word.rd[4:1],
        1'b0
    };

    assign imm.u = {
        word.funct7,
        word.rs2,
        word.rs1,
        word.funct3,
        12'b0
    };

    // J holds bits 20, 19:12, 11 and 10:1
    assign imm.j = {
        {(xlen - 20){sign}},
        word.rs1,
        word.funct3,
        word.rs2[0],
        word.funct7[5:0],
        word.rs2[4:1],
        1'b0
    };

endmodule

`default_nettype wire

//--- uop_decode.sv
`timescale 1ns/1ps
`default_nettype none

module uop_decode
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t word,
    output uop_t  uop
);

    imm_set_t imm;

    imm_gen u_imm_gen (
        .word (word),
        .imm  (imm)
    );

    // only reg_form picks sub over add since op-imm only has the shift alt
    function automatic alu_op_e alu_op_of(
        input logic [2:0] f3,
        input logic       alt,
        input logic       reg_form
    );
        alu_op_e op;
        case (f3)
            f3_add_sub: op = (reg_form && alt) ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
            default:    op = alu_none;
        endcase
        return op;
    endfunction

    function automatic br_cond_e br_cond_of(input logic [2:0] f3);
        br_cond_e cond;
        case (f3)
            f3_beq:           cond = br_eq;
            f3_bne:           cond = br_ne;
            f3_blt, f3_bltu:  cond = br_lt;
            f3_bge, f3_bgeu:  cond = br_ge;
            default:          cond = br_none;
        endcase
        return cond;
    endfunction

    always_comb begin
        uop = '0;
        case (word.opcode)
            op_load: begin
                uop.cls              = cls_ls;
                uop.src1.idx         = word.rs1;
                uop.src3.valid       = 1'b1;
                uop.src3.val         = imm.i;
                uop.mem.is_load      = 1'b1;
                uop.mem.size         = word.funct3[1:0];
                uop.mem.unsigned_ext = word.funct3[2];
            end
            op_store: begin
                uop.cls        = cls_ls;
                uop.src1.idx   = word.rs1;
                uop.src2.idx   = word.rs2;
                uop.src3.valid = 1'b1;
                uop.src3.val   = imm.s;
            end
            op_imm: begin
                uop.cls        = cls_alu;
                uop.src1.idx   = word.rs1;
                uop.src2.valid = 1'b1;
                uop.src2.val   = imm.i;
                uop.rd_idx     = word.rd;
                uop.alu_op     = alu_op_of(word.funct3, word[alt_bit_pos], 1'b0);
            end
            op_op: begin
                uop.cls      = cls_alu;
                uop.src1.idx = word.rs1;
                uop.src2.idx = word.rs2;
                uop.rd_idx   = word.rd;
                uop.alu_op   = alu_op_of(word.funct3, word[alt_bit_pos], 1'b1);
            end
            op_lui, op_auipc: begin
                uop.cls        = cls_ldpc;
                uop.src2.valid = 1'b1;
                uop.src2.val   = imm.u;
                uop.rd_idx     = word.rd;
                // auipc adds the pc but lui does not
                uop.need_pc    = (word.opcode == op_auipc);
            end
            op_branch: begin
                uop.cls              = cls_jmp;
                uop.src1.idx         = word.rs1;
                uop.src2.idx         = word.rs2;
                uop.src3.valid       = 1'b1;
                uop.src3.val         = imm.b;
                uop.jmp.cond         = br_cond_of(word.funct3);
                uop.jmp.cmp_unsigned = word.funct3[1];
            end
            op_jalr: begin
                uop.cls         = cls_jmp;
                uop.src1.idx    = word.rs1;
                uop.src2.valid  = 1'b1;
                uop.src2.val    = imm.i;
                uop.rd_idx      = word.rd;
                uop.jmp.is_jalr = 1'b1;
            end
            op_jal: begin
                uop.cls        = cls_jmp;
                uop.src2.valid = 1'b1;
                uop.src2.val   = imm.j;
                uop.rd_idx     = word.rd;
                uop.jmp.is_jal = 1'b1;
            end
            default: begin
                // unknown opcodes stay all zero
            end
        endcase
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            fetch_valid,
    input  inst_t           fetch_word,
    input  logic [xlen-1:0] fetch_pc,
    input  logic [xlen-1:0] fetch_next_pc,
    input  logic            down_ready,
    output logic            in_ready,
    output logic            out_valid,
    output uop_t            uop
);

    logic load;
    uop_t dec_uop;
    uop_t next_uop;

    fetch_handshake u_handshake (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .fetch_valid (fetch_valid),
        .down_ready  (down_ready),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .load        (load)
    );

    uop_decode u_decode (
        .word (fetch_word),
        .uop  (dec_uop)
    );

    // decoder leaves the pcs zero, fill them here
    always_comb begin
        next_uop         = dec_uop;
        next_uop.pc      = fetch_pc;
        next_uop.next_pc = fetch_next_pc;
    end

    // one entry output register
    always_ff @(posedge clk) begin
        if (rst) begin
            uop <= '0;
        end else if (load) begin
            uop <= next_uop;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb
    import rv_isa_pkg::*;
    import decode_pkg::*;
();

    // budget of three cycles per word plus setup
    localparam int test_words     = 32 + 20 + 40 + 50 + 20 + 2;
    localparam int test_cycles    = 3 * test_words + 10;
    localparam int timeout_cycles = 4 * test_cycles;

    logic            clk = 1'b0;
    logic            rst;
    logic            start;
    logic            fetch_valid;
    inst_t           fetch_word;
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] fetch_next_pc;
    logic            down_ready;
    logic            in_ready;
    logic            out_valid;
    uop_t            uop;
    logic [31:0]     rng = 32'hcf45780d;
    int              cycles = 0;
    logic [31:0]     words[$];
    logic [6:0]      valid_ops [9] = '{op_load, op_store, op_imm, op_op, op_lui,
                                       op_auipc, op_branch, op_jalr, op_jal};
    logic [2:0]      load_f3 [5] = '{f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu};

    always #4 clk = ~clk;

    decode_stage u_decode_stage (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .fetch_valid   (fetch_valid),
        .fetch_word    (fetch_word),
        .fetch_pc      (fetch_pc),
        .fetch_next_pc (fetch_next_pc),
        .down_ready    (down_ready),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .uop           (uop)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            fail_run($sformatf("timeout, run not finished after %0d cycles", timeout_cycles));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic cmp_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: uop.%s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_uop(input uop_t got, input uop_t exp);
        cmp_field("pc", 64'(got.pc), 64'(exp.pc));
        cmp_field("next_pc", 64'(got.next_pc), 64'(exp.next_pc));
        cmp_field("cls", 64'(got.cls), 64'(exp.cls));
        cmp_field("src1", 64'(got.src1), 64'(exp.src1));
        cmp_field("src2", 64'(got.src2), 64'(exp.src2));
        cmp_field("src3", 64'(got.src3), 64'(exp.src3));
        cmp_field("rd_idx", 64'(got.rd_idx), 64'(exp.rd_idx));
        cmp_field("alu_op", 64'(got.alu_op), 64'(exp.alu_op));
        cmp_field("mem", 64'(got.mem), 64'(exp.mem));
        cmp_field("jmp", 64'(got.jmp), 64'(exp.jmp));
        cmp_field("need_pc", 64'(got.need_pc), 64'(exp.need_pc));
    endtask

    function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic reg_form);
        case (f3)
            3'b000: return (alt && reg_form) ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b011: return alu_sltu;
            3'b100: return alu_xor;
            3'b101: return alt ? alu_sra : alu_srl;
            3'b110: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    function automatic br_cond_e ref_cond(input logic [2:0] f3);
        case (f3)
            3'b000: return br_eq;
            3'b001: return br_ne;
            3'b100, 3'b110: return br_lt;
            3'b101, 3'b111: return br_ge;
            default: return br_none;
        endcase
    endfunction

    // reference decoder built from the RV32I field layout
    function automatic uop_t ref_uop(input logic [31:0] w, input logic [31:0] pc,
                                     input logic [31:0] npc);
        uop_t        u;
        operand_t    rs1;
        operand_t    rs2;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        rs1 = '{1'b0, w[19:15], 32'h0};
        rs2 = '{1'b0, w[24:20], 32'h0};
        u = '0;
        u.pc = pc;
        u.next_pc = npc;
        case (w[6:0])
            op_load: begin
                u.cls = cls_ls;
                u.src1 = rs1;
                u.src3 = '{1'b1, 5'd0, imm_i};
                u.mem = '{1'b1, w[13:12], w[14]};
            end
            op_store: begin
                u.cls = cls_ls;
                u.src1 = rs1;
                u.src2 = rs2;
                u.src3 = '{1'b1, 5'd0, imm_s};
            end
            op_imm, op_op: begin
                u.cls = cls_alu;
                u.src1 = rs1;
                u.src2 = rs2;
                if (w[6:0] == op_imm) begin
                    u.src2 = '{1'b1, 5'd0, imm_i};
                end
                u.rd_idx = w[11:7];
                u.alu_op = ref_alu(w[14:12], w[30], w[6:0] == op_op);
            end
            op_lui, op_auipc: begin
                u.cls = cls_ldpc;
                u.src2 = '{1'b1, 5'd0, imm_u};
                u.rd_idx = w[11:7];
                u.need_pc = (w[6:0] == op_auipc);
            end
            op_branch: begin
                u.cls = cls_jmp;
                u.src1 = rs1;
                u.src2 = rs2;
                u.src3 = '{1'b1, 5'd0, imm_b};
                u.jmp.cond = ref_cond(w[14:12]);
                u.jmp.cmp_unsigned = w[13];
            end
            op_jalr: begin
                u.cls = cls_jmp;
                u.src1 = rs1;
                u.src2 = '{1'b1, 5'd0, imm_i};
                u.rd_idx = w[11:7];
                u.jmp.is_jalr = 1'b1;
            end
            op_jal: begin
                u.cls = cls_jmp;
                u.src2 = '{1'b1, 5'd0, imm_j};
                u.rd_idx = w[11:7];
                u.jmp.is_jal = 1'b1;
            end
            default: begin
                u.cls = cls_none;
            end
        endcase
        return u;
    endfunction

    // caller gives the top two bits and the register fields are random
    task automatic push_word(input logic [6:0] opcode, input logic [2:0] f3,
                             input logic [1:0] top);
        rng = xorshift32(rng);
        words.push_back({top, rng[29:15], f3, rng[11:7], opcode});
    endtask

    // sends the queued words and checks every uop as it leaves
    task automatic run_words(input bit random_ready);
        uop_t        exp_q[$];
        uop_t        held;
        logic [31:0] pc;
        logic [31:0] npc;
        logic        stalled;
        int          n;
        int          sent;
        int          got;
        n = words.size();
        sent = 0;
        got = 0;
        stalled = 1'b0;
        rng = xorshift32(rng);
        pc = {rng[31:2], 2'b00};
        while (got < n) begin
            if (stalled) begin
                check_uop(uop, held);
            end
            rng = xorshift32(rng);
            down_ready = random_ready ? rng[7] : 1'b1;
            // next pc as a random jump target
            npc = pc + {{21{rng[20]}}, rng[20:12], 2'b00};
            fetch_valid = (sent < n);
            if (sent < n) begin
                fetch_word = words[sent];
            end
            fetch_pc = pc;
            fetch_next_pc = npc;
            #1;
            // one item in flight and shown one cycle after acceptance
            check_bit("out_valid", out_valid, got < sent);
            check_bit("in_ready", in_ready, (got == sent) || down_ready);
            stalled = out_valid && !down_ready;
            if (stalled) begin
                held = uop;
            end else if (out_valid) begin
                check_uop(uop, exp_q.pop_front());
                got++;
            end
            if (in_ready && fetch_valid) begin
                exp_q.push_back(ref_uop(words[sent], pc, npc));
                sent++;
                pc = npc;
            end
            @(negedge clk);
        end
        fetch_valid = 1'b0;
        down_ready = 1'b0;
        words.delete();
    endtask

    task automatic test_idle_and_start();
        fetch_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("out_valid", out_valid, 1'b0);
        end
        fetch_valid = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
    endtask

    task automatic test_alu();
        int f3;
        for (f3 = 0; f3 < 8; f3++) begin
            push_word(op_imm, 3'(f3), 2'b00);
            push_word(op_imm, 3'(f3), 2'b11);
            push_word(op_op, 3'(f3), 2'b00);
            push_word(op_op, 3'(f3), 2'b01);
        end
        run_words(1'b0);
    endtask

    task automatic test_mem();
        int i;
        for (i = 0; i < 10; i++) begin
            push_word(op_load, load_f3[i % 5], 2'(i));
            push_word(op_store, 3'(i), 2'(i + 1));
        end
        run_words(1'b0);
    endtask

    task automatic test_ctrl();
        int i;
        for (i = 0; i < 8; i++) begin
            push_word(op_branch, 3'(i), 2'(i));
            push_word(op_jalr, 3'b000, 2'(i));
            push_word(op_jal, 3'(i), 2'(i + 1));
            push_word(op_lui, 3'(i), 2'(i + 2));
            push_word(op_auipc, 3'(i), 2'(i + 3));
        end
        run_words(1'b0);
    endtask

    task automatic test_stream();
        int i;
        int k;
        for (i = 0; i < 70; i++) begin
            rng = xorshift32(rng);
            k = int'(rng % 32'd9);
            push_word(valid_ops[k], rng[14:12], rng[31:30]);
            // random back-pressure first and full rate after
            if (i == 49) begin
                run_words(1'b1);
            end
        end
        run_words(1'b0);
    endtask

    task automatic test_restart_unknown();
        rng = xorshift32(rng);
        fetch_word = rng;
        fetch_word.opcode = op_op;
        fetch_valid = 1'b1;
        down_ready = 1'b0;
        @(negedge clk);
        fetch_valid = 1'b0;
        check_bit("out_valid", out_valid, 1'b1);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        push_word(7'b1111111, 3'b101, 2'b10);
        push_word(7'b0001111, 3'b000, 2'b01);
        run_words(1'b0);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        fetch_valid = 1'b0;
        fetch_word = '0;
        fetch_pc = '0;
        fetch_next_pc = '0;
        down_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_idle_and_start();
        test_alu();
        test_mem();
        test_ctrl();
        test_stream();
        test_restart_unknown();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- decode_stage.f
rv_isa_pkg.sv
decode_pkg.sv
fetch_handshake.sv
imm_gen.sv
uop_decode.sv
decode_stage.sv
decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run, a $fatal in the testbench gives a failing exit status
cd "$(dirname "$0")" &&
    verilator --binary -f decode_stage.f --top-module decode_stage_tb -o decode_stage_sim &&
    ./obj_dir/decode_stage_sim ||
    { echo "simulation run failed"; exit 1; }
